// ==== Makefile ====
TOP = mips_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f mips_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_core.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/ex_mem_if.sv ====
// execute to memory bundle
`timescale 1ns/1ps

interface ex_mem_if;
	import mips_pkg::*;

	logic      reg_write;  // never set for register 0.
	logic      mem_to_reg;
	logic      mem_read;
	logic      mem_write;
	word_t     alu_result; // also the memory byte address.
	word_t     store_data;
	reg_addr_t dest;

	modport src (
		output reg_write, mem_to_reg, mem_read, mem_write,
		output alu_result, store_data, dest
	);

	modport dst (
		input reg_write, mem_to_reg, mem_read, mem_write,
		input alu_result, store_data, dest
	);

endinterface

// ==== common/id_ex_if.sv ====
// decode to execute bundle
`timescale 1ns/1ps

interface id_ex_if;
	import mips_pkg::*;

	logic      reg_write;
	logic      mem_to_reg;
	logic      mem_read;
	logic      mem_write;
	logic      alu_src;   // immediate as second operand.
	logic      reg_dst;   // rd as destination, else rt.
	alu_op_t   alu_op;
	word_t     rs_data;
	word_t     rt_data;
	word_t     imm;       // already sign extended.
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	reg_addr_t rd_addr;

	modport src (
		output reg_write, mem_to_reg, mem_read, mem_write, alu_src, reg_dst,
		output alu_op, rs_data, rt_data, imm, rs_addr, rt_addr, rd_addr
	);

	modport dst (
		input reg_write, mem_to_reg, mem_read, mem_write, alu_src, reg_dst,
		input alu_op, rs_data, rt_data, imm, rs_addr, rt_addr, rd_addr
	);

endinterface

// ==== common/mips_pkg.sv ====
// mips pipeline shared types
package mips_pkg;

	// data and register widths.
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  alu_op_t;

	// alu operation codes.
	localparam alu_op_t ALU_AND = 3'b000;
	localparam alu_op_t ALU_OR  = 3'b001;
	localparam alu_op_t ALU_ADD = 3'b010;
	localparam alu_op_t ALU_SUB = 3'b110;
	localparam alu_op_t ALU_SLT = 3'b111;

	// primary opcodes, instr[31:26].
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// r-type function field, instr[5:0].
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// data memory size in words, power of two.
	localparam int DMEM_DEPTH_DEF = 64;

endpackage

// ==== decode/instr_decoder.sv ====
// instruction decode and register read
`timescale 1ns/1ps

module instr_decoder (
	input  logic               clk,
	input  logic               rst,
	input  mips_pkg::word_t    instr,
	input  logic               instr_valid,
	input  logic               wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t    wb_data,
	id_ex_if.src               dec_bus
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic       rf_we;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	assign dec_bus.rs_addr = instr[25:21];
	assign dec_bus.rt_addr = instr[20:16];
	assign dec_bus.rd_addr = instr[15:11];
	assign dec_bus.imm     = {{16{instr[15]}}, instr[15:0]};

	// hold off register writes while reset is asserted.
	assign rf_we = wb_en & rst;

	always_comb begin
		dec_bus.reg_write  = 1'b0; // bubble unless recognised.
		dec_bus.mem_to_reg = 1'b0;
		dec_bus.mem_read   = 1'b0;
		dec_bus.mem_write  = 1'b0;
		dec_bus.alu_src    = 1'b0;
		dec_bus.reg_dst    = 1'b0;
		dec_bus.alu_op     = ALU_AND;
		if (instr_valid) begin
			case (opcode)
				OP_RTYPE: begin
					dec_bus.reg_dst = 1'b1;
					case (funct)
						FN_ADD: begin dec_bus.reg_write = 1'b1; dec_bus.alu_op = ALU_ADD; end
						FN_SUB: begin dec_bus.reg_write = 1'b1; dec_bus.alu_op = ALU_SUB; end
						FN_AND: begin dec_bus.reg_write = 1'b1; dec_bus.alu_op = ALU_AND; end
						FN_OR:  begin dec_bus.reg_write = 1'b1; dec_bus.alu_op = ALU_OR;  end
						FN_SLT: begin dec_bus.reg_write = 1'b1; dec_bus.alu_op = ALU_SLT; end
						default: dec_bus.reg_dst = 1'b0;
					endcase
				end
				OP_ADDI: begin
					dec_bus.reg_write = 1'b1;
					dec_bus.alu_src   = 1'b1;
					dec_bus.alu_op    = ALU_ADD;
				end
				OP_LW: begin
					dec_bus.reg_write  = 1'b1;
					dec_bus.mem_to_reg = 1'b1;
					dec_bus.mem_read   = 1'b1;
					dec_bus.alu_src    = 1'b1;
					dec_bus.alu_op     = ALU_ADD; // base plus offset.
				end
				OP_SW: begin
					dec_bus.mem_write = 1'b1;
					dec_bus.alu_src   = 1'b1;
					dec_bus.alu_op    = ALU_ADD;
				end
				default: ;
			endcase
		end
	end

	reg_file i_reg_file (
		.clk     (clk),
		.ra_addr (dec_bus.rs_addr),
		.rb_addr (dec_bus.rt_addr),
		.ra_data (dec_bus.rs_data),
		.rb_data (dec_bus.rt_data),
		.we      (rf_we),
		.wa      (wb_addr),
		.wd      (wb_data)
	);

endmodule

// ==== decode/reg_file.sv ====
// general purpose register file
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  mips_pkg::reg_addr_t ra_addr,
	input  mips_pkg::reg_addr_t rb_addr,
	output mips_pkg::word_t     ra_data,
	output mips_pkg::word_t     rb_data,
	input  logic                we,
	input  mips_pkg::reg_addr_t wa,
	input  mips_pkg::word_t     wd
);
	import mips_pkg::*;

	word_t regs [0:31];

	always_ff @(posedge clk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// register 0 reads as zero, same-cycle write passes straight through.
	always_comb begin
		if (ra_addr == '0) ra_data = '0;
		else if (we && wa == ra_addr) ra_data = wd;
		else ra_data = regs[ra_addr];
	end

	always_comb begin
		if (rb_addr == '0) rb_data = '0;
		else if (we && wa == rb_addr) rb_data = wd;
		else rb_data = regs[rb_addr];
	end

endmodule

// ==== execute/exec_stage.sv ====
// execute stage with forwarding
`timescale 1ns/1ps

module exec_stage (
	input  logic                clk,
	input  logic                rst,
	id_ex_if.dst                ex_bus,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data,
	ex_mem_if.src               ex_mem
);
	import mips_pkg::*;

	word_t     op_a;
	word_t     op_b;  // forwarded rt, also the store data.
	word_t     alu_b;
	word_t     alu_y;
	reg_addr_t dest;

	// newest producer wins; a load in ex/mem has no result yet.
	function automatic word_t fwd_sel(input reg_addr_t src, input word_t rdata);
		word_t val;
		if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.dest == src) val = ex_mem.alu_result;
		else if (wb_en && wb_addr == src) val = wb_data;
		else val = rdata;
		return val;
	endfunction

	assign op_a  = fwd_sel(ex_bus.rs_addr, ex_bus.rs_data);
	assign op_b  = fwd_sel(ex_bus.rt_addr, ex_bus.rt_data);
	assign alu_b = ex_bus.alu_src ? ex_bus.imm : op_b;
	assign dest  = ex_bus.reg_dst ? ex_bus.rd_addr : ex_bus.rt_addr;

	always_comb begin
		case (ex_bus.alu_op)
			ALU_ADD: alu_y = op_a + alu_b;
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			ALU_OR:  alu_y = op_a | alu_b;
			ALU_SLT: alu_y = ($signed(op_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
			default: alu_y = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ex_mem.reg_write  <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_read   <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
			ex_mem.alu_result <= '0;
			ex_mem.store_data <= '0;
			ex_mem.dest       <= '0;
		end else begin
			ex_mem.reg_write  <= ex_bus.reg_write && (dest != '0); // r0 writes dropped here.
			ex_mem.mem_to_reg <= ex_bus.mem_to_reg;
			ex_mem.mem_read   <= ex_bus.mem_read;
			ex_mem.mem_write  <= ex_bus.mem_write;
			ex_mem.alu_result <= alu_y;
			ex_mem.store_data <= op_b;
			ex_mem.dest       <= dest;
		end
	end

endmodule

// ==== logic/id_ex.sv ====
// id/ex pipeline register
`timescale 1ns/1ps

module id_ex (
	input  logic  clk,
	input  logic  rst,
	id_ex_if.dst  dec_bus,
	id_ex_if.src  ex_bus
);

	// loads every cycle, everything clears on reset.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ex_bus.reg_write  <= 1'b0;
			ex_bus.mem_to_reg <= 1'b0;
			ex_bus.mem_read   <= 1'b0;
			ex_bus.mem_write  <= 1'b0;
			ex_bus.alu_src    <= 1'b0;
			ex_bus.reg_dst    <= 1'b0;
			ex_bus.alu_op     <= '0;
			ex_bus.rs_data    <= '0;
			ex_bus.rt_data    <= '0;
			ex_bus.imm        <= '0;
			ex_bus.rs_addr    <= '0;
			ex_bus.rt_addr    <= '0;
			ex_bus.rd_addr    <= '0;
		end else begin
			ex_bus.reg_write  <= dec_bus.reg_write;
			ex_bus.mem_to_reg <= dec_bus.mem_to_reg;
			ex_bus.mem_read   <= dec_bus.mem_read;
			ex_bus.mem_write  <= dec_bus.mem_write;
			ex_bus.alu_src    <= dec_bus.alu_src;
			ex_bus.reg_dst    <= dec_bus.reg_dst;
			ex_bus.alu_op     <= dec_bus.alu_op;
			ex_bus.rs_data    <= dec_bus.rs_data;
			ex_bus.rt_data    <= dec_bus.rt_data;
			ex_bus.imm        <= dec_bus.imm;
			ex_bus.rs_addr    <= dec_bus.rs_addr;
			ex_bus.rt_addr    <= dec_bus.rt_addr;
			ex_bus.rd_addr    <= dec_bus.rd_addr;
		end
	end

endmodule

// ==== logic/mem_wb_stage.sv ====
// data memory and writeback
`timescale 1ns/1ps

module mem_wb_stage #(
	parameter int DMEM_DEPTH = mips_pkg::DMEM_DEPTH_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	ex_mem_if.dst                ex_mem,
	output logic                 wb_en,
	output mips_pkg::reg_addr_t  wb_addr,
	output mips_pkg::word_t      wb_data
);
	import mips_pkg::*;

	localparam int ADDR_W = $clog2(DMEM_DEPTH);

	word_t             dmem [DMEM_DEPTH];
	logic [ADDR_W-1:0] mem_idx;
	word_t             load_data;

	// word index, wraps modulo depth.
	assign mem_idx   = ex_mem.alu_result[ADDR_W+1:2];
	assign load_data = ex_mem.mem_read ? dmem[mem_idx] : '0;

	always_ff @(posedge clk) begin
		if (ex_mem.mem_write) begin
			dmem[mem_idx] <= ex_mem.store_data;
		end
	end

	// mem/wb register, drives the writeback ports directly.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wb_en   <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
		end else begin
			wb_en   <= ex_mem.reg_write;
			wb_addr <= ex_mem.dest;
			wb_data <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
		end
	end

endmodule

// ==== logic/mips_core.sv ====
// mips integer pipeline top
`timescale 1ns/1ps

module mips_core #(
	parameter int DMEM_DEPTH = mips_pkg::DMEM_DEPTH_DEF
) (
	input  logic                clk,
	input  logic                rst,
	input  mips_pkg::word_t     instr,
	input  logic                instr_valid,
	output logic                wb_en,
	output mips_pkg::reg_addr_t wb_addr,
	output mips_pkg::word_t     wb_data
);

	id_ex_if  dec_bus ();
	id_ex_if  ex_bus ();
	ex_mem_if ex_mem ();

	instr_decoder i_instr_decoder (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.dec_bus     (dec_bus)
	);

	id_ex i_id_ex (
		.clk     (clk),
		.rst     (rst),
		.dec_bus (dec_bus),
		.ex_bus  (ex_bus)
	);

	exec_stage i_exec_stage (
		.clk     (clk),
		.rst     (rst),
		.ex_bus  (ex_bus),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.ex_mem  (ex_mem)
	);

	mem_wb_stage #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) i_mem_wb_stage (
		.clk     (clk),
		.rst     (rst),
		.ex_mem  (ex_mem),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

endmodule

// ==== mips_core.f ====
common/mips_pkg.sv
common/id_ex_if.sv
common/ex_mem_if.sv
decode/reg_file.sv
decode/instr_decoder.sv
logic/id_ex.sv
execute/exec_stage.sv
logic/mem_wb_stage.sv
logic/mips_core.sv
testbench/mips_core_checker.sv
testbench/mips_core_tb.sv

// ==== testbench/mips_core_checker.sv ====
// pipeline rule assertions
`timescale 1ns/1ps

module mips_core_checker (
	input logic                clk,
	input logic                rst,
	input mips_pkg::word_t     instr,
	input logic                instr_valid,
	input logic                wb_en,
	input mips_pkg::reg_addr_t wb_addr
);
	import mips_pkg::*;

	logic alu_issue;

	// valid alu instruction with a non-zero destination.
	always_comb begin
		alu_issue = 1'b0;
		if (instr_valid && instr[31:26] == OP_RTYPE) begin
			case (instr[5:0])
				FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: alu_issue = (instr[15:11] != '0);
				default: alu_issue = 1'b0;
			endcase
		end else if (instr_valid && instr[31:26] == OP_ADDI) begin
			alu_issue = (instr[20:16] != '0);
		end
	end

	reset_quiet: assert property (@(posedge clk) !rst |=> !wb_en)
		else $error("wb_en active while reset is asserted");

	wb_latency: assert property (@(posedge clk) disable iff (!rst) alu_issue |-> ##3 wb_en)
		else $error("alu instruction did not write back three edges later");

	wb_not_r0: assert property (@(posedge clk) disable iff (!rst) wb_en |-> wb_addr != '0)
		else $error("writeback to register 0");

endmodule

bind mips_core mips_core_checker i_mips_core_checker (
	.clk         (clk),
	.rst         (rst),
	.instr       (instr),
	.instr_valid (instr_valid),
	.wb_en       (wb_en),
	.wb_addr     (wb_addr)
);

// ==== testbench/mips_core_tb.sv ====
// mips pipeline testbench
`timescale 1ns/1ps

module mips_core_tb;
	import mips_pkg::*;

	localparam int PERIOD      = 40;
	localparam int DEPTH       = 8; // small memory so addresses wrap often.
	localparam int AW          = $clog2(DEPTH);
	localparam int SLOTS       = 400;
	localparam int WATCHDOG_NS = (SLOTS + 20) * PERIOD;

	logic      clk;
	logic      rst;
	word_t     instr;
	logic      instr_valid;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;

	int         seed = 20;
	int         issued = 0;
	reg_addr_t  last_lw = '0; // destination of the previous slot's load.
	word_t      model_reg [32];
	word_t      model_mem [DEPTH];
	reg_addr_t  exp_addr_q [$];
	word_t      exp_data_q [$];
	logic [5:0] fn_list [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};

	mips_core #(
		.DMEM_DEPTH (DEPTH)
	) i_mips_core (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic int rnd(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// word address above the byte offset, wrapped to the memory size.
	function automatic logic [AW-1:0] mem_index(input word_t addr);
		return AW'((addr >> 2) % DEPTH);
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic expect_write(input reg_addr_t d, input word_t v);
		if (d != '0) begin // register 0 never shows a writeback.
			model_reg[d] = v;
			exp_addr_q.push_back(d);
			exp_data_q.push_back(v);
		end
	endtask

	// architectural effect of one slot, in program order.
	task automatic model_step(input logic v, input word_t w);
		word_t a;
		word_t b;
		word_t imm;
		word_t lt;
		a   = model_reg[w[25:21]];
		b   = model_reg[w[20:16]];
		imm = {{16{w[15]}}, w[15:0]};
		lt  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		if (v) begin
			case (w[31:26])
				OP_RTYPE: begin
					case (w[5:0])
						FN_ADD: expect_write(w[15:11], a + b);
						FN_SUB: expect_write(w[15:11], a - b);
						FN_AND: expect_write(w[15:11], a & b);
						FN_OR:  expect_write(w[15:11], a | b);
						FN_SLT: expect_write(w[15:11], lt);
						default: ;
					endcase
				end
				OP_ADDI: expect_write(w[20:16], a + imm);
				OP_LW:   expect_write(w[20:16], model_mem[mem_index(a + imm)]);
				OP_SW:   model_mem[mem_index(a + imm)] = b;
				default: ;
			endcase
		end
	endtask

	task automatic issue_slot(input logic v, input word_t w);
		@(posedge clk);
		instr_valid <= v;
		instr       <= w;
		model_step(v, w);
		last_lw = (v && w[31:26] == OP_LW) ? w[20:16] : '0;
		issued++;
	endtask

	task automatic random_slot();
		int          kind;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		logic [15:0] imm;
		word_t       w;
		logic        v;
		kind = rnd(20);
		rs   = reg_addr_t'(rnd(8));
		rt   = reg_addr_t'(rnd(8));
		rd   = reg_addr_t'(rnd(8));
		imm  = 16'(rnd(65536));
		w    = $random(seed);
		v    = 1'b1;
		if (kind < 8) w = r_type(fn_list[3'(rnd(5))], rd, rs, rt);
		else if (kind < 11) w = i_type(OP_ADDI, rt, rs, imm);
		else if (kind < 14) w = i_type(OP_LW, rt, rs, imm);
		else if (kind < 17) w = i_type(OP_SW, rt, rs, imm);
		else if (kind == 17) v = 1'b0;         // idle slot.
		else if (kind == 18) w[31:26] = 6'h3f; // unknown opcode.
		else w = r_type(6'h00, rd, rs, rt);    // unsupported function.
		// no use of a load result in the very next slot.
		if (last_lw != '0 && (rs == last_lw || rt == last_lw)) v = 1'b0;
		issue_slot(v, w);
	endtask

	// compare each writeback with the oldest expected one.
	always @(negedge clk) begin
		if (rst && wb_en) check_writeback();
	end

	task automatic check_writeback();
		reg_addr_t ea;
		word_t     ed;
		assert (exp_addr_q.size() != 0)
			else fail_run("writeback seen while no result was expected");
		ea = exp_addr_q.pop_front();
		ed = exp_data_q.pop_front();
		assert (wb_addr == ea)
			else fail_run($sformatf("** Error: wb_addr expected %h, actual %h", ea, wb_addr));
		assert (wb_data == ed)
			else fail_run($sformatf("** Error: wb_data expected %h, actual %h", ed, wb_data));
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout: the writeback stream did not finish");
	end

	initial begin
		rst          = 1'b0;
		instr        = '0;
		instr_valid  = 1'b0;
		model_reg[0] = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		assert (wb_en == 1'b0)
			else fail_run($sformatf("** Error: wb_en expected %h, actual %h", 1'b0, wb_en));
		// registers 1 to 7, every memory word, then a wrapped store.
		for (int i = 1; i < 8; i++) begin
			issue_slot(1'b1, i_type(OP_ADDI, reg_addr_t'(i), '0, 16'(rnd(65536))));
		end
		for (int i = 0; i < DEPTH; i++) begin
			issue_slot(1'b1, i_type(OP_SW, reg_addr_t'(i % 7 + 1), '0, 16'(i * 4)));
		end
		issue_slot(1'b1, i_type(OP_SW, 5'd3, '0, 16'(DEPTH * 4)));
		// dependent pairs one, two and three slots apart.
		issue_slot(1'b1, r_type(FN_ADD, 5'd1, 5'd2, 5'd3));
		issue_slot(1'b1, r_type(FN_SUB, 5'd4, 5'd1, 5'd3)); // r1 from ex/mem.
		issue_slot(1'b1, r_type(FN_OR, 5'd5, 5'd2, 5'd3));
		issue_slot(1'b1, i_type(OP_ADDI, 5'd6, 5'd7, 16'hfffb));
		issue_slot(1'b1, r_type(FN_AND, 5'd7, 5'd5, 5'd4)); // r5 from mem/wb, r4 write-through.
		issue_slot(1'b1, r_type(FN_SLT, 5'd2, 5'd4, 5'd1));
		// store, then load the same word through a wrapped address.
		issue_slot(1'b1, i_type(OP_SW, 5'd7, 5'd0, 16'd12));
		issue_slot(1'b1, i_type(OP_ADDI, 5'd3, 5'd0, 16'd100));
		issue_slot(1'b1, i_type(OP_LW, 5'd2, 5'd0, 16'(12 + DEPTH * 4)));
		issue_slot(1'b1, r_type(FN_ADD, 5'd1, 5'd3, 5'd3));
		issue_slot(1'b1, r_type(FN_OR, 5'd5, 5'd2, 5'd0)); // loaded word from mem/wb.
		while (issued < SLOTS) random_slot();
		@(posedge clk);
		instr_valid <= 1'b0;
		repeat (4) @(posedge clk); // three edges to writeback, one spare.
		if (exp_addr_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			fail_run("results still pending at the end of the run");
		end
	end

endmodule
